// ==== of_stream_pkg.sv ====
package of_stream_pkg;

   // Beat payload and byte strobe
   typedef logic [63:0] data_t;
   typedef logic [7:0]  strb_t;

   // One bit per port, used for both source and destination
   typedef logic [7:0]  port_mask_t;

   // Packet length in bytes
   typedef logic [15:0] pkt_len_t;

   // Sideband layout
   // dst_port in 31:24, src_port in 23:16, len in 15:0
   typedef struct packed {
      port_mask_t dst_port;
      port_mask_t src_port;
      pkt_len_t   len;
   } user_t;

   // Stream beat as it travels between stages
   typedef struct packed {
      data_t data;
      strb_t strb;
      user_t user;
      logic  last;
   } axis_beat_t;

endpackage

// ==== of_flow_pkg.sv ====
package of_flow_pkg;

   import of_stream_pkg::*;

   // Header field types
   typedef logic [47:0] mac_t;
   typedef logic [15:0] ethertype_t;

   // Lookup key taken from the first beat of a packet
   typedef struct packed {
      port_mask_t src_port;
      ethertype_t ethertype;
      mac_t       mac;
   } flow_key_t;

   // Masked table entry
   // A mask bit of 1 means the key bit must compare equal
   typedef struct packed {
      logic       valid;
      flow_key_t  key;
      flow_key_t  mask;
      port_mask_t action;
   } flow_entry_t;

   // Statistics counter
   typedef logic [31:0] counter_t;

   // Parser to lookup
   typedef struct packed {
      axis_beat_t beat;
      flow_key_t  key;
      logic       sop;
   } parsed_beat_t;

   // Lookup to action stage
   typedef struct packed {
      axis_beat_t beat;
      port_mask_t action;
   } action_beat_t;

endpackage

// ==== of_header_parser.sv ====
`timescale 1ns/1ps

module of_header_parser
   import of_stream_pkg::*;
   import of_flow_pkg::*;
(
   input  logic         asclk,
   input  logic         rst_n,

   // Incoming stream
   input  axis_beat_t   in_beat,
   input  logic         in_valid,
   output logic         in_ready,

   // Towards the lookup stage
   output parsed_beat_t parse_beat,
   output logic         parse_valid,
   input  logic         parse_ready
);

   logic      sop;
   logic      accept;
   flow_key_t first_key;
   flow_key_t pkt_key;

   // Single output register, free when empty or draining
   assign in_ready = !parse_valid || parse_ready;
   assign accept   = in_valid && in_ready;

   // Key fields sit in the first beat and its sideband
   assign first_key.src_port  = in_beat.user.src_port;
   assign first_key.ethertype = in_beat.data[15:0];
   assign first_key.mac       = in_beat.data[63:16];

   always_ff @(posedge asclk) begin
      if (!rst_n) begin
         sop         <= 1'b1;
         parse_valid <= 1'b0;
      end else begin
         if (accept) begin
            // Next beat starts a packet once this one closes it
            sop         <= in_beat.last;
            parse_valid <= 1'b1;
         end else if (parse_ready) begin
            parse_valid <= 1'b0;
         end
      end
   end

   // Beat register
   always_ff @(posedge asclk) begin
      if (accept) begin
         parse_beat.beat <= in_beat;
         parse_beat.key  <= sop ? first_key : pkt_key;
         parse_beat.sop  <= sop;
         if (sop) begin
            pkt_key <= first_key;
         end
      end
   end

endmodule

// ==== of_flow_lookup.sv ====
`timescale 1ns/1ps

module of_flow_lookup
   import of_stream_pkg::*;
   import of_flow_pkg::*;
#(
   parameter int TBL_DEPTH = 8
)
(
   input  logic                         asclk,
   input  logic                         rst_n,

   // From the parser
   input  parsed_beat_t                 parse_beat,
   input  logic                         parse_valid,
   output logic                         parse_ready,

   // Table write port
   input  logic                         tbl_wr,
   input  logic [$clog2(TBL_DEPTH)-1:0] tbl_addr,
   input  flow_entry_t                  tbl_entry,

   // Towards the action stage
   output action_beat_t                 act_beat,
   output logic                         act_valid,
   input  logic                         act_ready,

   // Per-packet lookup statistics
   output counter_t                     lookup_hits,
   output counter_t                     lookup_misses
);

   flow_entry_t tbl [TBL_DEPTH];
   logic        accept;
   logic        hit;
   port_mask_t  hit_action;
   port_mask_t  pkt_action;

   assign parse_ready = !act_valid || act_ready;
   assign accept      = parse_valid && parse_ready;

   // Flow table
   always_ff @(posedge asclk) begin
      if (!rst_n) begin
         for (int i = 0; i < TBL_DEPTH; i++) begin
            tbl[i] <= '0;
         end
      end else if (tbl_wr) begin
         tbl[tbl_addr] <= tbl_entry;
      end
   end

   // Masked compare against all entries
   // Scan from the top so the lowest index wins
   always_comb begin
      hit        = 1'b0;
      hit_action = '0;
      for (int i = TBL_DEPTH - 1; i >= 0; i--) begin
         if (tbl[i].valid &&
             ((parse_beat.key ^ tbl[i].key) & tbl[i].mask) == '0) begin
            hit        = 1'b1;
            hit_action = tbl[i].action;
         end
      end
   end

   // Handshake, action latch and counters
   always_ff @(posedge asclk) begin
      if (!rst_n) begin
         act_valid     <= 1'b0;
         pkt_action    <= '0;
         lookup_hits   <= '0;
         lookup_misses <= '0;
      end else begin
         if (accept) begin
            act_valid <= 1'b1;
         end else if (act_ready) begin
            act_valid <= 1'b0;
         end

         if (accept && parse_beat.sop) begin
            // Miss leaves a zero action, which drops the packet
            pkt_action <= hit_action;
            if (hit) begin
               lookup_hits <= lookup_hits + 1'b1;
            end else begin
               lookup_misses <= lookup_misses + 1'b1;
            end
         end
      end
   end

   // Beat register
   // First beat takes the fresh result, the rest reuse the latch
   always_ff @(posedge asclk) begin
      if (accept) begin
         act_beat.beat   <= parse_beat.beat;
         act_beat.action <= parse_beat.sop ? hit_action : pkt_action;
      end
   end

endmodule

// ==== of_action_apply.sv ====
`timescale 1ns/1ps

module of_action_apply
   import of_stream_pkg::*;
   import of_flow_pkg::*;
(
   input  logic         asclk,
   input  logic         rst_n,

   // From the lookup stage
   input  action_beat_t act_beat,
   input  logic         act_valid,
   output logic         act_ready,

   // Outgoing stream
   output axis_beat_t   out_beat,
   output logic         out_valid,
   input  logic         out_ready,

   output counter_t     pkts_dropped
);

   logic       accept;
   logic       drop;
   axis_beat_t fwd_beat;

   assign act_ready = !out_valid || out_ready;
   assign accept    = act_valid && act_ready;

   // Empty port bitmap means no destination
   assign drop = (act_beat.action == '0);

   // Destination field replaced by the flow's ports
   always_comb begin
      fwd_beat               = act_beat.beat;
      fwd_beat.user.dst_port = act_beat.action;
   end

   always_ff @(posedge asclk) begin
      if (!rst_n) begin
         out_valid    <= 1'b0;
         pkts_dropped <= '0;
      end else begin
         if (accept && !drop) begin
            out_valid <= 1'b1;
         end else if (out_ready) begin
            out_valid <= 1'b0;
         end

         // One count per dropped packet, on its last beat
         if (accept && drop && act_beat.beat.last) begin
            pkts_dropped <= pkts_dropped + 1'b1;
         end
      end
   end

   // Dropped beats are swallowed here
   always_ff @(posedge asclk) begin
      if (accept && !drop) begin
         out_beat <= fwd_beat;
      end
   end

endmodule

// ==== of_datapath.sv ====
`timescale 1ns/1ps

module of_datapath
   import of_stream_pkg::*;
   import of_flow_pkg::*;
#(
   parameter int TBL_DEPTH = 8
)
(
   input  logic                         asclk,
   input  logic                         rst_n,

   // Input stream
   input  axis_beat_t                   in_beat,
   input  logic                         in_valid,
   output logic                         in_ready,

   // Output stream
   output axis_beat_t                   out_beat,
   output logic                         out_valid,
   input  logic                         out_ready,

   // Flow table writes
   input  logic                         tbl_wr,
   input  logic [$clog2(TBL_DEPTH)-1:0] tbl_addr,
   input  flow_entry_t                  tbl_entry,

   // Statistics
   output counter_t                     lookup_hits,
   output counter_t                     lookup_misses,
   output counter_t                     pkts_dropped
);

   parsed_beat_t parse_beat;
   logic         parse_valid;
   logic         parse_ready;

   action_beat_t act_beat;
   logic         act_valid;
   logic         act_ready;

   // Stage 1, flow key extraction
   of_header_parser header_parser (
      .asclk       (asclk),
      .rst_n       (rst_n),
      .in_beat     (in_beat),
      .in_valid    (in_valid),
      .in_ready    (in_ready),
      .parse_beat  (parse_beat),
      .parse_valid (parse_valid),
      .parse_ready (parse_ready)
   );

   // Stage 2, table match
   of_flow_lookup #(
      .TBL_DEPTH (TBL_DEPTH)
   ) flow_lookup (
      .asclk         (asclk),
      .rst_n         (rst_n),
      .parse_beat    (parse_beat),
      .parse_valid   (parse_valid),
      .parse_ready   (parse_ready),
      .tbl_wr        (tbl_wr),
      .tbl_addr      (tbl_addr),
      .tbl_entry     (tbl_entry),
      .act_beat      (act_beat),
      .act_valid     (act_valid),
      .act_ready     (act_ready),
      .lookup_hits   (lookup_hits),
      .lookup_misses (lookup_misses)
   );

   // Stage 3, port rewrite and drop
   of_action_apply action_apply (
      .asclk        (asclk),
      .rst_n        (rst_n),
      .act_beat     (act_beat),
      .act_valid    (act_valid),
      .act_ready    (act_ready),
      .out_beat     (out_beat),
      .out_valid    (out_valid),
      .out_ready    (out_ready),
      .pkts_dropped (pkts_dropped)
   );

endmodule

// ==== of_datapath_properties.sv ====
`timescale 1ns/1ps

module of_datapath_properties
   import of_stream_pkg::*;
   import of_flow_pkg::*;
(
   input logic       asclk,
   input logic       rst_n,
   input logic       in_valid,
   input logic       in_ready,
   input axis_beat_t out_beat,
   input logic       out_valid,
   input logic       out_ready,
   input counter_t   lookup_hits,
   input counter_t   lookup_misses,
   input counter_t   pkts_dropped
);

   // Output beat held while the sink stalls
   out_hold: assert property (@(posedge asclk) disable iff (!rst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_beat))
      else $error("out_beat changed or vanished while out_ready was low");

   // A full pipeline moves nothing, so no counter can step
   stall_counters: assert property (@(posedge asclk) disable iff (!rst_n)
      in_valid && !in_ready |=> $stable(lookup_hits) && $stable(lookup_misses)
         && $stable(pkts_dropped))
      else $error("counter changed while the input was stalled");

   reset_idle: assert property (@(posedge asclk)
      !rst_n |=> !out_valid)
      else $error("out_valid high in the cycle after reset");

endmodule

bind of_datapath of_datapath_properties props0 (.*);

// ==== of_datapath_tb.sv ====
`timescale 1ns/1ps

module of_datapath_tb
   import of_stream_pkg::*;
   import of_flow_pkg::*;
();

   localparam int          TBL_DEPTH = 8;
   localparam int          TIMEOUT   = 2000;
   localparam logic [31:0] SEED      = 32'd70;

   // Keys for the directed tests
   localparam flow_key_t KEY_A = {8'h01, 16'h0800, 48'h0200_0000_000a};
   localparam flow_key_t KEY_P = {8'h04, 16'h86dd, 48'h0200_0000_0050};
   localparam flow_key_t KEY_Q = {8'h04, 16'h0800, 48'h0200_0000_0050};
   localparam flow_key_t KEY_M = {8'h08, 16'h0806, 48'h0200_0000_00ff};
   localparam flow_key_t KEY_Z = {8'h02, 16'h88cc, 48'h0200_0000_0033};

   localparam flow_key_t FULL_MASK    = '1;
   localparam flow_key_t ETH_MASK     = {8'h00, 16'hffff, 48'h0};
   localparam flow_key_t SRC_MAC_MASK = {8'hff, 16'h0000, 48'hffff_ffff_ffff};

   logic                         asclk;
   logic                         rst_n;
   axis_beat_t                   in_beat;
   logic                         in_valid;
   logic                         in_ready;
   axis_beat_t                   out_beat;
   logic                         out_valid;
   logic                         out_ready;
   logic                         tbl_wr;
   logic [$clog2(TBL_DEPTH)-1:0] tbl_addr;
   flow_entry_t                  tbl_entry;
   counter_t                     lookup_hits;
   counter_t                     lookup_misses;
   counter_t                     pkts_dropped;

   // Reference table and expected results
   flow_entry_t model_tbl [TBL_DEPTH];
   axis_beat_t  exp_q [$];
   int          acc_q [$];
   counter_t    exp_hits;
   counter_t    exp_misses;
   counter_t    exp_drops;
   logic [31:0] rng_state;
   logic [31:0] rdy_state;
   logic        random_ready;
   int          cyc = 0;
   string       test_name;

   of_datapath #(.TBL_DEPTH(TBL_DEPTH)) dut0 (
      .asclk         (asclk),
      .rst_n         (rst_n),
      .in_beat       (in_beat),
      .in_valid      (in_valid),
      .in_ready      (in_ready),
      .out_beat      (out_beat),
      .out_valid     (out_valid),
      .out_ready     (out_ready),
      .tbl_wr        (tbl_wr),
      .tbl_addr      (tbl_addr),
      .tbl_entry     (tbl_entry),
      .lookup_hits   (lookup_hits),
      .lookup_misses (lookup_misses),
      .pkts_dropped  (pkts_dropped)
   );

   initial begin
      asclk = 1'b0;
      forever #50 asclk = ~asclk;
   end

   always @(posedge asclk) begin
      cyc <= cyc + 1;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   task automatic report_fail(input string msg);
      $display("%s", msg);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic compare_beat(input axis_beat_t exp_b, input axis_beat_t act_b);
      if (act_b !== exp_b)
         report_fail($sformatf("Error: %s beat expected %h actual %h",
                               test_name, exp_b, act_b));
   endtask

   task automatic compare_ports(input port_mask_t exp_p, input port_mask_t act_p);
      if (act_p !== exp_p)
         report_fail($sformatf("Error: %s dst ports expected %h actual %h",
                               test_name, exp_p, act_p));
   endtask

   task automatic compare_counter(input string what, input counter_t exp_c,
                                  input counter_t act_c);
      if (act_c !== exp_c)
         report_fail($sformatf("Error: %s %s expected %0d actual %0d",
                               test_name, what, exp_c, act_c));
   endtask

   // About three cycles in four ready when stalling is enabled
   always @(posedge asclk) begin
      #1;
      if (random_ready) begin
         rdy_state = xorshift32(rdy_state);
         out_ready = rdy_state[4] | rdy_state[9];
      end else begin
         out_ready = 1'b1;
      end
   end

   // Output monitor, latency checked only for timed beats
   always @(posedge asclk) begin
      axis_beat_t exp_beat;
      int         acc;
      if (rst_n && out_valid && out_ready) begin
         if (exp_q.size() == 0)
            report_fail("Output beat appeared when none was expected");
         exp_beat = exp_q.pop_front();
         acc      = acc_q.pop_front();
         compare_ports(exp_beat.user.dst_port, out_beat.user.dst_port);
         compare_beat(exp_beat, out_beat);
         if (acc >= 0 && cyc != acc + 3)
            report_fail($sformatf("Error: %s latency expected %0d actual %0d",
                                  test_name, 3, cyc - acc));
      end
   end

   function automatic flow_entry_t make_entry(input flow_key_t key, input flow_key_t mask,
                                              input port_mask_t ports);
      flow_entry_t e;
      e.valid  = 1'b1;
      e.key    = key;
      e.mask   = mask;
      e.action = ports;
      return e;
   endfunction

   function automatic logic entry_matches(input flow_entry_t e, input flow_key_t key);
      return e.valid && ((key & e.mask) == (e.key & e.mask));
   endfunction

   task automatic write_entry(input int addr, input flow_entry_t e);
      tbl_wr    = 1'b1;
      tbl_addr  = addr[$clog2(TBL_DEPTH)-1:0];
      tbl_entry = e;
      @(posedge asclk);
      #1;
      tbl_wr         = 1'b0;
      model_tbl[addr] = e;
   endtask

   // Drives one packet and queues what should come out of it
   task automatic send_pkt(input flow_key_t key, input int nbeats, input bit timed);
      axis_beat_t  b;
      logic        hit;
      port_mask_t  ports;
      logic [31:0] r;
      int          n;
      hit   = 1'b0;
      ports = '0;
      for (int i = 0; i < TBL_DEPTH; i++) begin
         if (!hit && entry_matches(model_tbl[i], key)) begin
            hit   = 1'b1;
            ports = model_tbl[i].action;
         end
      end
      if (hit)
         exp_hits = exp_hits + 32'd1;
      else
         exp_misses = exp_misses + 32'd1;
      if (ports == '0)
         exp_drops = exp_drops + 32'd1;
      r = next_rand();
      for (int i = 0; i < nbeats; i++) begin
         b.data          = (i == 0) ? {key.mac, key.ethertype} : {next_rand(), next_rand()};
         b.last          = (i == nbeats - 1);
         b.strb          = b.last ? (8'hff >> r[2:0]) : 8'hff;
         b.user.src_port = key.src_port;
         b.user.dst_port = r[15:8];
         b.user.len      = pkt_len_t'(nbeats * 8 - int'(r[2:0]));
         in_beat  = b;
         in_valid = 1'b1;
         n        = 0;
         do begin
            @(posedge asclk);
            n++;
            if (n > TIMEOUT)
               report_fail("Timeout: the DUT never accepted an input beat");
         end while (!in_ready);
         if (ports != '0) begin
            b.user.dst_port = ports;
            exp_q.push_back(b);
            acc_q.push_back(timed ? cyc : -1);
         end
         #1;
      end
      in_valid = 1'b0;
   endtask

   // Pipeline is three deep, so four idle cycles flush any dropped beats
   task automatic drain();
      int n;
      n = 0;
      while (exp_q.size() != 0) begin
         @(posedge asclk);
         n++;
         if (n > TIMEOUT)
            report_fail("Timeout: expected output beats never arrived");
      end
      repeat (4) @(posedge asclk);
      #1;
      compare_counter("lookup_hits", exp_hits, lookup_hits);
      compare_counter("lookup_misses", exp_misses, lookup_misses);
      compare_counter("pkts_dropped", exp_drops, pkts_dropped);
   endtask

   task automatic test_reset();
      test_name = "reset";
      if (out_valid !== 1'b0)
         report_fail("out_valid is not low after reset");
      compare_counter("lookup_hits", '0, lookup_hits);
      compare_counter("lookup_misses", '0, lookup_misses);
      compare_counter("pkts_dropped", '0, pkts_dropped);
      send_pkt(KEY_A, 2, 1'b1);
      drain();
   endtask

   task automatic test_exact();
      test_name = "exact";
      write_entry(0, make_entry(KEY_A, FULL_MASK, 8'h06));
      send_pkt(KEY_A, 3, 1'b1);
      drain();
      compare_counter("lookup_hits", 32'd1, lookup_hits);
   endtask

   // Entry 2 looks at the ethertype only, entry 5 at source port and MAC
   task automatic test_priority();
      test_name = "priority";
      write_entry(2, make_entry(KEY_P, ETH_MASK, 8'h10));
      write_entry(5, make_entry(KEY_Q, SRC_MAC_MASK, 8'h20));
      send_pkt(KEY_P, 2, 1'b1);
      send_pkt(KEY_Q, 1, 1'b1);
      drain();
   endtask

   task automatic test_drops();
      test_name = "drops";
      write_entry(3, make_entry(KEY_Z, FULL_MASK, 8'h00));
      send_pkt(KEY_M, 2, 1'b1);
      send_pkt(KEY_Z, 3, 1'b1);
      send_pkt(KEY_A, 2, 1'b1);
      drain();
   endtask

   task automatic test_backpressure();
      logic [31:0] r;
      logic [31:0] mac_lo;
      flow_key_t   key;
      test_name    = "backpressure";
      random_ready = 1'b1;
      for (int p = 0; p < 20; p++) begin
         r = next_rand();
         case (r[2:0])
            3'd0: key = KEY_A;
            3'd1: key = KEY_P;
            3'd2: key = KEY_Q;
            3'd3: key = KEY_M;
            3'd4: key = KEY_Z;
            default: begin
               mac_lo = next_rand();
               key    = {r[15:8], r[31:16], r[7:0], mac_lo, 8'h00};
            end
         endcase
         send_pkt(key, int'(r[5:4]) + 1, 1'b0);
      end
      drain();
      random_ready = 1'b0;
   endtask

   task automatic test_rewrite();
      flow_entry_t e;
      test_name = "rewrite";
      send_pkt(KEY_A, 2, 1'b1);
      drain();
      e = make_entry(KEY_A, FULL_MASK, 8'h41);
      write_entry(0, e);
      send_pkt(KEY_A, 2, 1'b1);
      drain();
      e.valid = 1'b0;
      write_entry(0, e);
      send_pkt(KEY_A, 1, 1'b1);
      drain();
   endtask

   initial begin
      rst_n        = 1'b0;
      in_beat      = '0;
      in_valid     = 1'b0;
      out_ready    = 1'b1;
      tbl_wr       = 1'b0;
      tbl_addr     = '0;
      tbl_entry    = '0;
      random_ready = 1'b0;
      rng_state    = SEED;
      rdy_state    = SEED;
      exp_hits     = '0;
      exp_misses   = '0;
      exp_drops    = '0;
      test_name    = "init";
      for (int i = 0; i < TBL_DEPTH; i++)
         model_tbl[i] = '0;
      repeat (5) @(posedge asclk);
      #1;
      rst_n = 1'b1;
      test_reset();
      test_exact();
      test_priority();
      test_drops();
      test_backpressure();
      test_rewrite();
      if (exp_q.size() == 0) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         report_fail("Expected output beats were left over at the end");
      end
   end

endmodule

// ==== of_datapath.f ====
of_stream_pkg.sv
of_flow_pkg.sv
of_header_parser.sv
of_flow_lookup.sv
of_action_apply.sv
of_datapath.sv
of_datapath_properties.sv
of_datapath_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   --top-module of_datapath_tb \
   -f of_datapath.f \
   -o of_datapath_sim

./obj_dir/of_datapath_sim 2>&1 | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
   echo "run_sim: simulation passed"
else
   echo "run_sim: simulation failed"
   exit 1
fi
